// ==== logic/cgra_defs.svh ====
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// words handled in one pass through the tile
`define TILE_DEPTH 32

// buffer address width, log2 of the depth
`define TILE_AW 5

// data word width, also used for coefficient and bias
`define TILE_DW 16

`endif

// ==== logic/cgra_pkg.sv ====
`include "cgra_defs.svh"

package cgra_pkg;

    // one data word in a tile buffer
    typedef logic [`TILE_DW-1:0] word_t;

    // buffer address
    typedef logic [`TILE_AW-1:0] addr_t;

    // multiplier coefficient and bias, same width as a word
    typedef logic [`TILE_DW-1:0] coef_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        DRAIN,
        DONE
    } tile_state_t;

endpackage

// ==== logic/agu.sv ====
`timescale 1ns/1ps
`include "cgra_defs.svh"

module agu (
    input  logic            clk,
    input  logic            rst,
    input  logic            en,
    input  logic            start,
    output cgra_pkg::addr_t data,
    output logic            last
);
    import cgra_pkg::*;

    addr_t cnt;
    logic  running;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (en) begin
            if (start) begin
                cnt     <= '0;
                running <= 1'b1;
            end else if (running) begin
                // drop out after the final address was issued
                if (cnt == addr_t'(`TILE_DEPTH - 1)) begin
                    running <= 1'b0;
                end
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign data = cnt;
    assign last = running && (cnt == addr_t'(`TILE_DEPTH - 1));

endmodule

// ==== logic/tile_mem.sv ====
`timescale 1ns/1ps
`include "cgra_defs.svh"

module tile_mem (
    input  logic            clk,
    input  logic            wr_en,
    input  cgra_pkg::addr_t wr_addr,
    input  cgra_pkg::word_t wr_data,
    input  logic            rd_en,
    input  cgra_pkg::addr_t rd_addr,
    output cgra_pkg::word_t rd_data
);
    import cgra_pkg::*;

    word_t mem [`TILE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read register holds its value while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== logic/src_ctrl.sv ====
`timescale 1ns/1ps

module src_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            src_start,
    output logic            rd_en,
    output cgra_pkg::addr_t rd_addr,
    output logic            in_valid,
    output cgra_pkg::addr_t in_addr,
    output logic            in_last,
    input  logic            out_last,
    output logic            src_done
);
    import cgra_pkg::*;

    logic clr;
    logic busy;
    logic agu_last;

    assign clr = rst | ~run;

    agu u_agu (
        .clk   (clk),
        .rst   (clr),
        .en    (1'b1),
        .start (src_start),
        .data  (rd_addr),
        .last  (agu_last)
    );

    // one read per cycle from the first address through the last
    always_ff @(posedge clk) begin
        if (clr) begin
            busy <= 1'b0;
        end else if (src_start) begin
            busy <= 1'b1;
        end else if (agu_last) begin
            busy <= 1'b0;
        end
    end

    assign rd_en = busy;

    // line up with the registered memory output
    always_ff @(posedge clk) begin
        if (clr) begin
            in_valid <= 1'b0;
            in_last  <= 1'b0;
        end else begin
            in_valid <= rd_en;
            in_last  <= rd_en & agu_last;
        end
    end

    always_ff @(posedge clk) begin
        in_addr <= rd_addr;
    end

    // last tag came back out of the PE, pass is written
    always_ff @(posedge clk) begin
        if (clr) begin
            src_done <= 1'b0;
        end else begin
            src_done <= out_last;
        end
    end

endmodule

// ==== logic/pe_mac.sv ====
`timescale 1ns/1ps

module pe_mac (
    input  logic            clk,
    input  logic            rst,
    input  cgra_pkg::coef_t coef,
    input  cgra_pkg::coef_t bias,
    input  logic            in_valid,
    input  cgra_pkg::addr_t in_addr,
    input  cgra_pkg::word_t in_data,
    input  logic            in_last,
    output logic            out_valid,
    output cgra_pkg::addr_t out_addr,
    output cgra_pkg::word_t out_data,
    output logic            out_last
);
    import cgra_pkg::*;

    logic  p1_valid;
    logic  p1_last;
    addr_t p1_addr;
    word_t p1_prod;

    // control bits for both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            p1_valid  <= 1'b0;
            p1_last   <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            p1_valid  <= in_valid;
            p1_last   <= in_valid & in_last;
            out_valid <= p1_valid;
            out_last  <= p1_valid & p1_last;
        end
    end

    // stage one keeps only the low half of the product
    // stage two adds bias, wrapping mod 2^16
    always_ff @(posedge clk) begin
        p1_addr  <= in_addr;
        p1_prod  <= in_data * coef;
        out_addr <= p1_addr;
        out_data <= p1_prod + bias;
    end

endmodule

// ==== logic/dst_ctrl.sv ====
`timescale 1ns/1ps

module dst_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            dst_ready,
    input  logic            s_fin,
    output logic            dst_valid,
    output logic            dst_last,
    output logic            stream_v,
    output cgra_pkg::addr_t stream_a
);
    import cgra_pkg::*;

    logic clr;
    logic start_hold;
    logic start;
    logic stream_active;
    logic agu_last;

    assign clr = rst | ~run;

    // s_fin is a single pulse, keep it until the consumer is ready
    always_ff @(posedge clk) begin
        if (clr) begin
            start_hold <= 1'b0;
        end else if (s_fin) begin
            start_hold <= 1'b1;
        end else if (dst_ready) begin
            start_hold <= 1'b0;
        end
    end

    assign start = start_hold & dst_ready;

    // address walk frozen whenever dst_ready is low
    agu u_agu (
        .clk   (clk),
        .rst   (clr),
        .en    (dst_ready),
        .start (start),
        .data  (stream_a),
        .last  (agu_last)
    );

    always_ff @(posedge clk) begin
        if (clr) begin
            stream_active <= 1'b0;
        end else if (start) begin
            stream_active <= 1'b1;
        end else if (dst_ready & agu_last) begin
            stream_active <= 1'b0;
        end
    end

    // also the read enable of the destination buffer
    assign stream_v = stream_active & dst_ready;

    // one cycle behind the read, matches dst_data
    always_ff @(posedge clk) begin
        if (clr) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active & agu_last;
        end
    end

endmodule

// ==== logic/tile_ctrl.sv ====
`timescale 1ns/1ps

module tile_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic src_done,
    input  logic dst_valid,
    input  logic dst_last,
    input  logic dst_ready,
    output logic src_start,
    output logic s_fin,
    output logic done
);
    import cgra_pkg::*;

    tile_state_t state;

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            state     <= IDLE;
            src_start <= 1'b0;
            s_fin     <= 1'b0;
            done      <= 1'b0;
        end else begin
            src_start <= 1'b0;
            s_fin     <= 1'b0;
            case (state)
                IDLE: begin
                    // reached only on the first cycle after run rises
                    state     <= COMPUTE;
                    src_start <= 1'b1;
                end
                COMPUTE: begin
                    if (src_done) begin
                        state <= DRAIN;
                        s_fin <= 1'b1;
                    end
                end
                DRAIN: begin
                    // final word accepted by the consumer
                    if (dst_valid && dst_last && dst_ready) begin
                        state <= DONE;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    // hold DONE until run falls
                    state <= DONE;
                end
            endcase
        end
    end

endmodule

// ==== logic/cgra_tile.sv ====
`timescale 1ns/1ps

module cgra_tile (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            load_en,
    input  cgra_pkg::addr_t load_addr,
    input  cgra_pkg::word_t load_data,
    input  cgra_pkg::coef_t coef,
    input  cgra_pkg::coef_t bias,
    input  logic            dst_ready,
    output logic            dst_valid,
    output logic            dst_last,
    output cgra_pkg::word_t dst_data,
    output logic            done
);
    import cgra_pkg::*;

    logic  src_start;
    logic  src_done;
    logic  s_fin;
    logic  src_wr_en;
    logic  rd_en;
    addr_t rd_addr;
    word_t src_data;
    logic  in_valid;
    addr_t in_addr;
    logic  in_last;
    logic  out_valid;
    addr_t out_addr;
    word_t out_data;
    logic  out_last;
    logic  stream_v;
    addr_t stream_a;

    // host loads only while the tile is stopped
    assign src_wr_en = load_en & ~run;

    tile_ctrl u_tile_ctrl (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .src_done  (src_done),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .dst_ready (dst_ready),
        .src_start (src_start),
        .s_fin     (s_fin),
        .done      (done)
    );

    tile_mem src_buf (
        .clk     (clk),
        .wr_en   (src_wr_en),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (src_data)
    );

    src_ctrl u_src_ctrl (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .src_start (src_start),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .in_valid  (in_valid),
        .in_addr   (in_addr),
        .in_last   (in_last),
        .out_last  (out_last),
        .src_done  (src_done)
    );

    pe_mac u_pe_mac (
        .clk       (clk),
        .rst       (rst),
        .coef      (coef),
        .bias      (bias),
        .in_valid  (in_valid),
        .in_addr   (in_addr),
        .in_data   (src_data),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    tile_mem dst_buf (
        .clk     (clk),
        .wr_en   (out_valid),
        .wr_addr (out_addr),
        .wr_data (out_data),
        .rd_en   (stream_v),
        .rd_addr (stream_a),
        .rd_data (dst_data)
    );

    dst_ctrl u_dst_ctrl (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .dst_ready (dst_ready),
        .s_fin     (s_fin),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .stream_v  (stream_v),
        .stream_a  (stream_a)
    );

endmodule

// ==== sim/cgra_tile_chk.sv ====
`timescale 1ns/1ps

module cgra_tile_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  run,
    input logic                  dst_ready,
    input logic                  dst_valid,
    input logic                  dst_last,
    input cgra_pkg::word_t       dst_data,
    input logic                  done,
    input logic                  src_start,
    input logic                  s_fin,
    input cgra_pkg::tile_state_t state
);
    import cgra_pkg::*;

    last_has_valid: assert property (@(posedge clk) disable iff (rst)
        dst_last |-> dst_valid)
        else $error("dst_last high without dst_valid");

    // output register frozen while the consumer stalls
    hold_valid: assert property (@(posedge clk) disable iff (rst)
        (run && !dst_ready) |=> $stable(dst_valid))
        else $error("dst_valid changed while dst_ready was low");

    hold_data: assert property (@(posedge clk) disable iff (rst)
        (run && dst_valid && !dst_ready) |=> $stable(dst_data))
        else $error("dst_data changed while dst_ready was low");

    // completion only once the output stream has drained
    done_in_state: assert property (@(posedge clk) disable iff (rst)
        done |-> (state == DONE && !dst_valid))
        else $error("done high outside the DONE state or before the stream ended");

    start_pulse: assert property (@(posedge clk) disable iff (rst)
        src_start |=> !src_start)
        else $error("src_start longer than one cycle");

    fin_pulse: assert property (@(posedge clk) disable iff (rst)
        s_fin |=> !s_fin)
        else $error("s_fin longer than one cycle");

endmodule

bind cgra_tile cgra_tile_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .dst_ready (dst_ready),
    .dst_valid (dst_valid),
    .dst_last  (dst_last),
    .dst_data  (dst_data),
    .done      (done),
    .src_start (src_start),
    .s_fin     (s_fin),
    .state     (u_tile_ctrl.state)
);

// ==== sim/cgra_tile_tb.sv ====
`timescale 1ns/1ps
`include "cgra_defs.svh"

module cgra_tile_tb;
    import cgra_pkg::*;

    // source pass plus a stream at 25% ready plus slack for each pass
    localparam int PASS_CYCLES    = 35 + 4 * `TILE_DEPTH + 20;
    localparam int N_PASSES       = 10;
    localparam int TIMEOUT_CYCLES = N_PASSES * PASS_CYCLES;
    localparam logic [31:0] SEED  = 32'hee9d_6b09;

    logic  clk = 1'b0;
    logic  rst;
    logic  run;
    logic  load_en;
    addr_t load_addr;
    word_t load_data;
    coef_t coef;
    coef_t bias;
    logic  dst_ready;
    logic  dst_valid;
    logic  dst_last;
    word_t dst_data;
    logic  done;

    logic [31:0] rng;
    logic [31:0] ready_state;
    bit          bp_on = 1'b0;
    word_t       src_img [`TILE_DEPTH];
    word_t       exp_q [$];
    int          rx_total = 0;
    int          rx_base = 0;
    int          cycles = 0;
    string       test_name = "reset";

    cgra_tile uut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .coef      (coef),
        .bias      (bias),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .dst_data  (dst_data),
        .done      (done)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // low half of the full product plus bias with wrap-around
    function automatic word_t mac_ref(input word_t x, input coef_t c, input coef_t b);
        logic [31:0] full;
        full = {16'h0, x} * {16'h0, c};
        return full[15:0] + b;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic draw_word(output word_t w);
        rng = lcg_next(rng);
        w = rng[31:16];
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s expected %04h actual %04h", name, exp, act));
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s dst_last expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s flag expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("ERR %s count expected %0d actual %0d", name, exp, act));
        end
    endtask

    // random words or a descending pattern near the top of the range
    task automatic load_buffer(input bit use_max);
        addr_t a;
        for (int i = 0; i < `TILE_DEPTH; i++) begin
            a = addr_t'(i);
            if (use_max) begin
                src_img[a] = 16'hffff - word_t'(i);
            end else begin
                draw_word(src_img[a]);
            end
            load_en   = 1'b1;
            load_addr = a;
            load_data = src_img[a];
            tick();
        end
        load_en = 1'b0;
    endtask

    task automatic queue_expected();
        addr_t a;
        exp_q.delete();
        rx_base = rx_total;
        for (int i = 0; i < `TILE_DEPTH; i++) begin
            a = addr_t'(i);
            exp_q.push_back(mac_ref(src_img[a], coef, bias));
        end
    endtask

    task automatic run_pass(input string name, input bit bp, input bit poke);
        int n;
        n = 0;
        test_name = name;
        queue_expected();
        bp_on = bp;
        run   = 1'b1;
        while (!done) begin
            if (poke) begin
                // the top level must drop these while run is high
                load_en   = 1'b1;
                load_addr = addr_t'(n);
                load_data = ~src_img[addr_t'(n)];
                n++;
            end
            tick();
        end
        load_en = 1'b0;
        bp_on   = 1'b0;
        check_count(name, `TILE_DEPTH, rx_total - rx_base);
        repeat (3) begin
            tick();
            check_flag(name, 1'b1, done);
        end
        run = 1'b0;
        tick();
        check_flag(name, 1'b0, done);
    endtask

    task automatic drop_run_mid_stream(input string name);
        test_name = name;
        queue_expected();
        run = 1'b1;
        tick();
        while (rx_total - rx_base < `TILE_DEPTH / 2) begin
            tick();
        end
        run = 1'b0;
        tick();
        // rest of the stream is abandoned with the pass
        exp_q.delete();
        repeat (3) begin
            check_flag(name, 1'b0, dst_valid);
            check_flag(name, 1'b0, dst_last);
            check_flag(name, 1'b0, done);
            tick();
        end
    endtask

    // consumer ready pattern about 60% high under back-pressure
    initial begin
        bit use_bp;
        bit in_reset;
        ready_state = SEED;
        dst_ready   = 1'b0;
        forever begin
            @(posedge clk);
            use_bp   = bp_on;
            in_reset = rst;
            #1;
            if (in_reset) begin
                dst_ready = 1'b0;
            end else if (use_bp) begin
                ready_state = lcg_next(ready_state);
                dst_ready   = (ready_state[31:24] < 8'd154);
            end else begin
                dst_ready = 1'b1;
            end
        end
    end

    // one word taken per valid and ready edge
    always @(posedge clk) begin
        if (!rst && dst_valid && dst_ready) begin
            if (exp_q.size() == 0) begin
                stop_on_error("an output word arrived when no word was expected");
            end else begin
                check_word(test_name, exp_q[0], dst_data);
                check_last(test_name, (rx_total - rx_base == `TILE_DEPTH - 1), dst_last);
                void'(exp_q.pop_front());
                rx_total <= rx_total + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout, the run did not end within %0d cycles",
                                    TIMEOUT_CYCLES));
        end
    end

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        coef      = '0;
        bias      = '0;
        rng       = SEED;
        repeat (16) tick();
        rst = 1'b0;
        tick();

        load_buffer(1'b0);
        draw_word(coef);
        draw_word(bias);
        run_pass("basic", 1'b0, 1'b0);

        load_buffer(1'b0);
        draw_word(coef);
        draw_word(bias);
        run_pass("backpressure", 1'b1, 1'b0);

        // coefficient corners over the same data
        coef = '0;
        draw_word(bias);
        run_pass("coef zero", 1'b0, 1'b0);
        coef = 16'd1;
        bias = '0;
        run_pass("coef one", 1'b0, 1'b0);
        load_buffer(1'b1);
        coef = 16'hfffd;
        bias = 16'hff00;
        run_pass("wrap", 1'b0, 1'b0);

        draw_word(coef);
        draw_word(bias);
        drop_run_mid_stream("run drop");
        run_pass("run drop restart", 1'b0, 1'b0);

        load_buffer(1'b0);
        draw_word(coef);
        draw_word(bias);
        run_pass("write during run", 1'b0, 1'b1);

        for (int p = 0; p < 2; p++) begin
            load_buffer(1'b0);
            draw_word(coef);
            draw_word(bias);
            run_pass($sformatf("back to back %0d", p), 1'b0, 1'b0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/cgra_pkg.sv
logic/agu.sv
logic/tile_mem.sv
logic/src_ctrl.sv
logic/pe_mac.sv
logic/dst_ctrl.sv
logic/tile_ctrl.sv
logic/cgra_tile.sv
sim/cgra_tile_chk.sv
sim/cgra_tile_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cgra_tile_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep '^>>> PASS$$' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
